// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := niuCoreTb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Checks failed
PASS_MSG  := All checks passed
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard design/*.svh tests/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/alu.sv ====
`timescale 1ns/100ps
`include "niu_defines.svh"

module alu import niuPkg::*; (
    input  opcodeT func,
    input  wordT   a,
    input  wordT   b,
    output wordT   result
);

    logic [$clog2(`niuWordBits)-1:0] shamt;

    assign shamt = b[$clog2(`niuWordBits)-1:0];   // Low five bits only

    always_comb begin
        case (func)
            `niuFnSub: result = a - b;
            `niuFnAdd: result = a + b;
            `niuFnMlt: result = $signed(a) * $signed(b);   // Low word of product
            `niuFnNot: result = ~a;
            `niuFnAnd: result = a & b;
            `niuFnOr:  result = a | b;
            `niuFnXor: result = a ^ b;
            `niuFnSul: result = a << shamt;
            `niuFnSsl: result = a <<< shamt;
            `niuFnSur: result = a >> shamt;
            `niuFnSsr: result = $signed(a) >>> shamt;
            // Branch conditions, 1 or 0
            `niuFnEq:  result = wordT'(a == b);
            `niuFnNeq: result = wordT'(a != b);
            `niuFnLt:  result = wordT'($signed(a) < $signed(b));
            `niuFnLeq: result = wordT'($signed(a) <= $signed(b));
            default:   result = '0;
        endcase
    end

endmodule

// ==== design/controlUnit.sv ====
`timescale 1ns/100ps
`include "niu_defines.svh"

module controlUnit import niuPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  instrFieldsT fields,
    input  wordT        aluResult,
    output ctrlSignalsT ctrl,
    output logic        halted
);

    niuStateT state;
    niuStateT nextState;
    opcodeT   cmpFunc;
    logic     isRegOp;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= Fetch;
        end else begin
            state <= nextState;
        end
    end

    assign halted  = (state == Halt);
    assign isRegOp = (fields.op1 == `niuOpAlui);

    // Branch opcode to comparison code
    always_comb begin
        case (fields.op1)
            `niuOpBne: cmpFunc = `niuFnNeq;
            `niuOpBlt: cmpFunc = `niuFnLt;
            `niuOpBle: cmpFunc = `niuFnLeq;
            default:   cmpFunc = `niuFnEq;
        endcase
    end

    always_comb begin
        nextState = state;
        case (state)
            Fetch:  nextState = Decode;
            Decode: begin
                case (fields.op1)
                    `niuOpAlui: nextState = AluReg;
                    `niuOpAddi, `niuOpMlti, `niuOpAndi, `niuOpOri, `niuOpXori,
                    `niuOpSuli, `niuOpSsli, `niuOpSuri, `niuOpSsri: nextState = AluImm;
                    `niuOpLw, `niuOpSw: nextState = MemBase;
                    `niuOpBeq, `niuOpBne, `niuOpBlt, `niuOpBle: nextState = BrLoadA;
                    `niuOpJal: nextState = JumpLink;
                    default:   nextState = Halt;     // Illegal opcode
                endcase
            end
            AluImm, AluReg: nextState = AluLoadA;
            AluLoadA:       nextState = AluWrite;
            MemBase:        nextState = MemOffset;
            MemOffset:      nextState = MemAddr;
            MemAddr:        nextState = (fields.op1 == `niuOpLw) ? LoadWrite : StoreWrite;
            BrLoadA:        nextState = BrLoadB;
            BrLoadB:        nextState = BrCompare;
            BrCompare:      nextState = aluResult[0] ? BrLoadPc : Fetch;
            BrLoadPc:       nextState = BrLoadOffset;
            BrLoadOffset:   nextState = BrWritePc;
            JumpLink:       nextState = JumpGo;
            AluWrite, LoadWrite, StoreWrite, BrWritePc, JumpGo: nextState = Fetch;
            default:        nextState = Halt;
        endcase
    end

    // Control word, one per state
    always_comb begin
        ctrl         = '0;
        ctrl.busSrc  = BusNone;
        ctrl.aluFunc = `niuFnAdd;
        case (state)
            Fetch: begin
                ctrl.ldIr  = 1'b1;
                ctrl.incPc = 1'b1;
            end
            AluImm, MemOffset: begin
                ctrl.busSrc = BusImm;
                ctrl.ldB    = 1'b1;
            end
            AluReg, BrLoadB: begin
                ctrl.regSel = fields.ry;
                ctrl.busSrc = BusReg;
                ctrl.ldB    = 1'b1;
            end
            AluLoadA, MemBase, BrLoadA: begin
                ctrl.regSel = fields.rx;
                ctrl.busSrc = BusReg;
                ctrl.ldA    = 1'b1;
            end
            AluWrite: begin
                ctrl.aluFunc = isRegOp ? fields.op2 : fields.op1;
                ctrl.regSel  = isRegOp ? fields.rz : fields.ry;   // Immediate form writes ry
                ctrl.busSrc  = BusAlu;
                ctrl.wrReg   = 1'b1;
            end
            MemAddr: begin
                ctrl.busSrc = BusAlu;   // rx + imm
                ctrl.ldMar  = 1'b1;
            end
            LoadWrite: begin
                ctrl.regSel = fields.ry;
                ctrl.busSrc = BusMem;
                ctrl.wrReg  = 1'b1;
            end
            StoreWrite: begin
                ctrl.regSel = fields.ry;
                ctrl.busSrc = BusReg;
                ctrl.wrMem  = 1'b1;
            end
            BrCompare: ctrl.aluFunc = cmpFunc;
            BrLoadPc: begin
                ctrl.busSrc = BusPc;    // PC already points past the branch
                ctrl.ldA    = 1'b1;
            end
            BrLoadOffset: begin
                ctrl.busSrc = BusShiftedImm;
                ctrl.ldB    = 1'b1;
            end
            BrWritePc: begin
                ctrl.busSrc = BusAlu;
                ctrl.ldPc   = 1'b1;
            end
            JumpLink: begin
                ctrl.regSel = fields.ry;
                ctrl.busSrc = BusPc;
                ctrl.wrReg  = 1'b1;
            end
            JumpGo: begin
                ctrl.regSel = fields.rx;
                ctrl.busSrc = BusReg;
                ctrl.ldPc   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== design/dataPath.sv ====
`timescale 1ns/100ps
`include "niu_defines.svh"

module dataPath import niuPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  ctrlSignalsT ctrl,
    input  wordT        instrWord,
    input  wordT        memData,
    output instrFieldsT fields,
    output wordT        aluResult,
    output wordT        pc,
    output wordT        bus
);

    wordT ir;
    wordT regA;
    wordT regB;
    wordT regData;
    wordT immExt;
    wordT immShifted;
    immT  imm;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `niuPcStart;
        end else if (ctrl.ldPc) begin
            pc <= bus;
        end else if (ctrl.incPc) begin
            pc <= pc + `niuInstrBytes;
        end
    end

    // IR comes straight from instruction memory, A and B from the bus
    always_ff @(posedge clk) begin
        if (ctrl.ldIr) begin
            ir <= instrWord;
        end
        if (ctrl.ldA) begin
            regA <= bus;
        end
        if (ctrl.ldB) begin
            regB <= bus;
        end
    end

    // Instruction format: op1 | rx | ry | rz or imm | op2
    assign fields.op1 = ir[31:27];
    assign fields.rx  = ir[26:22];
    assign fields.ry  = ir[21:17];
    assign fields.rz  = ir[16:12];
    assign fields.op2 = ir[4:0];

    assign imm        = ir[`niuImmBits-1:0];
    assign immExt     = {{(`niuWordBits - `niuImmBits){imm[`niuImmBits-1]}}, imm};
    assign immShifted = immExt << $clog2(`niuInstrBytes);   // Word offset to bytes

    always_comb begin
        case (ctrl.busSrc)
            BusPc:         bus = pc;
            BusReg:        bus = regData;
            BusMem:        bus = memData;
            BusImm:        bus = immExt;
            BusShiftedImm: bus = immShifted;
            BusAlu:        bus = aluResult;
            default:       bus = '0;
        endcase
    end

    regFile i_regFile (
        .clk    (clk),
        .wrEn   (ctrl.wrReg),
        .sel    (ctrl.regSel),
        .wrData (bus),
        .rdData (regData)
    );

    alu i_alu (
        .func   (ctrl.aluFunc),
        .a      (regA),
        .b      (regB),
        .result (aluResult)
    );

endmodule

// ==== design/memorySystem.sv ====
`timescale 1ns/100ps
`include "niu_defines.svh"

module memorySystem import niuPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  ctrlSignalsT ctrl,
    input  wordT        pc,
    input  wordT        bus,
    input  logic        progWrite,
    input  memIndexT    progAddr,
    input  wordT        progData,
    input  wordT        switches,
    output wordT        instrWord,
    output wordT        memData,
    output logic        ledValid,
    output wordT        ledData
);

    localparam int memWords   = 1 << `niuMemAddrBits;
    localparam int byteOffset = $clog2(`niuInstrBytes);

    wordT     imem [memWords];
    wordT     dmem [memWords];
    wordT     mar;
    memIndexT pcIndex;
    memIndexT marIndex;
    logic     isLed;
    logic     isSwitch;
    logic     ledWrite;

    assign pcIndex  = pc[`niuMemAddrBits+byteOffset-1:byteOffset];
    assign marIndex = mar[`niuMemAddrBits+byteOffset-1:byteOffset];
    assign isLed    = (mar == `niuAddrLed);     // Full address compare
    assign isSwitch = (mar == `niuAddrSwitch);
    assign ledWrite = ctrl.wrMem && isLed;

    // Program load port
    always_ff @(posedge clk) begin
        if (progWrite) begin
            imem[progAddr] <= progData;
        end
    end

    assign instrWord = imem[pcIndex];

    always_ff @(posedge clk) begin
        if (ctrl.ldMar) begin
            mar <= bus;
        end
        if (ctrl.wrMem && !isLed) begin
            dmem[marIndex] <= bus;
        end
    end

    assign memData = isSwitch ? switches : dmem[marIndex];

    // LED strobe lasts one cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ledValid <= 1'b0;
            ledData  <= '0;
        end else begin
            ledValid <= ledWrite;
            if (ledWrite) begin
                ledData <= bus;
            end
        end
    end

endmodule

// ==== design/niuCore.sv ====
`timescale 1ns/100ps

module niuCore import niuPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     progWrite,
    input  memIndexT progAddr,
    input  wordT     progData,
    input  wordT     switches,
    output logic     ledValid,
    output wordT     ledData,
    output logic     halted
);

    ctrlSignalsT ctrl;
    instrFieldsT fields;
    wordT        aluResult;
    wordT        pc;
    wordT        bus;
    wordT        instrWord;
    wordT        memData;

    controlUnit i_controlUnit (
        .clk       (clk),
        .reset     (reset),
        .fields    (fields),
        .aluResult (aluResult),
        .ctrl      (ctrl),
        .halted    (halted)
    );

    dataPath i_dataPath (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .instrWord (instrWord),
        .memData   (memData),
        .fields    (fields),
        .aluResult (aluResult),
        .pc        (pc),
        .bus       (bus)
    );

    memorySystem i_memorySystem (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .pc        (pc),
        .bus       (bus),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .switches  (switches),
        .instrWord (instrWord),
        .memData   (memData),
        .ledValid  (ledValid),
        .ledData   (ledData)
    );

endmodule

// ==== design/niuPkg.sv ====
`include "niu_defines.svh"

package niuPkg;

    typedef logic [`niuWordBits-1:0]    wordT;
    typedef logic [`niuRegBits-1:0]     regSelT;
    typedef logic [`niuOpBits-1:0]      opcodeT;
    typedef logic [`niuImmBits-1:0]     immT;
    typedef logic [`niuMemAddrBits-1:0] memIndexT;

    // One state per bus transfer
    typedef enum logic [4:0] {
        Fetch, Decode,
        AluImm, AluReg, AluLoadA, AluWrite,
        MemBase, MemOffset, MemAddr, LoadWrite, StoreWrite,
        BrLoadA, BrLoadB, BrCompare, BrLoadPc, BrLoadOffset, BrWritePc,
        JumpLink, JumpGo,
        Halt
    } niuStateT;

    typedef enum logic [2:0] {
        BusNone, BusPc, BusReg, BusMem, BusImm, BusShiftedImm, BusAlu
    } busSrcT;

    typedef struct packed {
        logic   ldPc;
        logic   incPc;
        logic   ldIr;
        logic   ldA;
        logic   ldB;
        logic   ldMar;
        logic   wrReg;
        logic   wrMem;
        regSelT regSel;
        opcodeT aluFunc;
        busSrcT busSrc;   // Single bus driver
    } ctrlSignalsT;

    typedef struct packed {
        opcodeT op1;
        regSelT rx;
        regSelT ry;
        regSelT rz;
        opcodeT op2;      // Register ALU ops only
    } instrFieldsT;

endpackage

// ==== design/niu_defines.svh ====
`ifndef NIU_DEFINES_SVH
`define NIU_DEFINES_SVH

// Datapath widths
`define niuWordBits    32
`define niuRegBits     5
`define niuOpBits      5
`define niuImmBits     17
`define niuMemAddrBits 11              // 2048 words per memory
`define niuInstrBytes  32'd4           // PC step
`define niuPcStart     32'h0000_0000

// Memory-mapped I/O
`define niuAddrLed     32'hFFFF_0020
`define niuAddrSwitch  32'hFFFF_0120

// Primary opcodes
`define niuOpAlui 5'b00000
`define niuOpAddi 5'b00001
`define niuOpMlti 5'b00010
`define niuOpAndi 5'b00101
`define niuOpOri  5'b00110
`define niuOpXori 5'b00111
`define niuOpSuli 5'b01000
`define niuOpSsli 5'b01001
`define niuOpSuri 5'b01010
`define niuOpSsri 5'b01011
`define niuOpLw   5'b10000
`define niuOpSw   5'b10011
`define niuOpBeq  5'b11000
`define niuOpBne  5'b11001
`define niuOpBlt  5'b11010
`define niuOpBle  5'b11011
`define niuOpJal  5'b11111

// ALU function codes, the immediate opcodes reuse these values
`define niuFnSub 5'b00000
`define niuFnAdd 5'b00001
`define niuFnMlt 5'b00010
`define niuFnNot 5'b00100
`define niuFnAnd 5'b00101
`define niuFnOr  5'b00110
`define niuFnXor 5'b00111
`define niuFnSul 5'b01000
`define niuFnSsl 5'b01001
`define niuFnSur 5'b01010
`define niuFnSsr 5'b01011
`define niuFnEq  5'b10000
`define niuFnNeq 5'b10001
`define niuFnLt  5'b10010
`define niuFnLeq 5'b10011

`endif

// ==== design/regFile.sv ====
`timescale 1ns/100ps
`include "niu_defines.svh"

module regFile import niuPkg::*; (
    input  logic   clk,
    input  logic   wrEn,
    input  regSelT sel,
    input  wordT   wrData,
    output wordT   rdData
);

    localparam int numRegs = 1 << `niuRegBits;

    wordT regs [numRegs];

    // Read and write share one select
    always_ff @(posedge clk) begin
        if (wrEn) begin
            regs[sel] <= wrData;
        end
    end

    assign rdData = regs[sel];

endmodule

// ==== filelist.f ====
+incdir+design
+incdir+tests
design/niuPkg.sv
design/alu.sv
design/regFile.sv
design/dataPath.sv
design/controlUnit.sv
design/memorySystem.sv
design/niuCore.sv
tests/niuCoreTb.sv

// ==== tests/niuProgramsTb.svh ====
`ifndef NIU_PROGRAMS_TB_SVH
`define NIU_PROGRAMS_TB_SVH

localparam regSelT rZero     = 5'd0;
localparam regSelT rLed      = 5'd30;   // Holds the LED address in every program
localparam opcodeT opIllegal = 5'b11110;

// Field layout op1 | rx | ry | rz or imm | op2
function automatic wordT regInstr(opcodeT fn, regSelT rz, regSelT rx, regSelT ry);
    return {`niuOpAlui, rx, ry, rz, 7'd0, fn};
endfunction

function automatic wordT immInstr(opcodeT op, regSelT ry, regSelT rx, immT imm);
    return {op, rx, ry, imm};
endfunction

// Loaded or stored register in ry and base in rx
function automatic wordT memInstr(opcodeT op, regSelT ry, regSelT rx, immT offset);
    return {op, rx, ry, offset};
endfunction

function automatic wordT branchInstr(opcodeT op, regSelT rx, regSelT ry, immT words);
    return {op, rx, ry, words};
endfunction

function automatic wordT jalInstr(regSelT link, regSelT target);
    return {`niuOpJal, target, link, 17'd0};
endfunction

// Two's complement value of the 17-bit field
function automatic wordT signExtend(immT imm);
    if (imm[`niuImmBits-1]) begin
        return wordT'(imm) - (32'd1 << `niuImmBits);
    end
    return wordT'(imm);
endfunction

function automatic logic branchTaken(opcodeT op, wordT x, wordT y);
    case (op)
        `niuOpBeq: return x == y;
        `niuOpBne: return x != y;
        `niuOpBlt: return $signed(x) < $signed(y);
        default:   return $signed(x) <= $signed(y);
    endcase
endfunction

function automatic void emit(wordT instr);
    prog.push_back(instr);
endfunction

// Any 32-bit constant in three instructions
function automatic void loadConst(regSelT r, wordT value);
    emit(immInstr(`niuOpAddi, r, rZero, {1'b0, value[31:16]}));
    emit(immInstr(`niuOpSuli, r, r, 17'd16));
    emit(immInstr(`niuOpOri, r, r, {1'b0, value[15:0]}));
endfunction

function automatic void showReg(regSelT r, wordT expected);
    emit(memInstr(`niuOpSw, r, rLed, 17'd0));
    expectQ.push_back(expected);
endfunction

function automatic void startProgram();
    prog.delete();
    expectQ.delete();
    emit(regInstr(`niuFnSub, rZero, rZero, rZero));     // r0 = 0 whatever it held
    emit(immInstr(`niuOpAddi, rLed, rZero, 17'h10020)); // Sign extends to FFFF0020
endfunction

function automatic void endProgram();
    emit({opIllegal, 27'd0});
    instrTotal += prog.size();
endfunction

function automatic void buildRegAluProgram();
    wordT a;
    wordT b;
    a = $urandom();
    b = $urandom();
    startProgram();
    loadConst(5'd1, a);
    loadConst(5'd2, b);
    emit(regInstr(`niuFnAdd, 5'd3, 5'd1, 5'd2));
    showReg(5'd3, a + b);
    emit(regInstr(`niuFnSub, 5'd3, 5'd1, 5'd2));
    showReg(5'd3, a - b);
    emit(regInstr(`niuFnAnd, 5'd3, 5'd1, 5'd2));
    showReg(5'd3, a & b);
    emit(regInstr(`niuFnOr, 5'd3, 5'd1, 5'd2));
    showReg(5'd3, a | b);
    emit(regInstr(`niuFnXor, 5'd3, 5'd1, 5'd2));
    showReg(5'd3, a ^ b);
    emit(regInstr(`niuFnNot, 5'd3, 5'd1, 5'd2));
    showReg(5'd3, ~a);
    emit(regInstr(`niuFnMlt, 5'd3, 5'd1, 5'd2));
    showReg(5'd3, a * b);   // Low word wraps
    endProgram();
endfunction

function automatic void immCheck(opcodeT op, immT imm, wordT expected);
    emit(immInstr(op, 5'd2, 5'd1, imm));
    showReg(5'd2, expected);
endfunction

function automatic void buildImmProgram();
    wordT a;
    immT  imm;
    int   s;
    a = $urandom() | 32'h8000_0000;   // Negative so SSRI shifts in ones
    startProgram();
    loadConst(5'd1, a);
    immCheck(`niuOpAddi, 17'h1FFFB, a + signExtend(17'h1FFFB));   // Minus five
    imm = immT'($urandom());
    immCheck(`niuOpAddi, imm, a + signExtend(imm));
    imm = immT'($urandom());
    immCheck(`niuOpMlti, imm, a * signExtend(imm));
    imm = immT'($urandom()) | 17'h10000;
    immCheck(`niuOpAndi, imm, a & signExtend(imm));
    imm = immT'($urandom()) & 17'h0FFFF;
    immCheck(`niuOpOri, imm, a | signExtend(imm));
    imm = immT'($urandom());
    immCheck(`niuOpXori, imm, a ^ signExtend(imm));
    s = $urandom() % 32;
    immCheck(`niuOpSuli, immT'(s), a << s);
    s = $urandom() % 32;
    immCheck(`niuOpSsli, immT'(s), a << s);
    s = $urandom() % 32;
    immCheck(`niuOpSuri, immT'(s), a >> s);
    s = $urandom() % 32;
    immCheck(`niuOpSsri, immT'(s), wordT'($signed(a) >>> s));
    endProgram();
endfunction

function automatic void buildMemProgram();
    wordT vals[4];
    immT  offs[4];
    int   k;
    offs = '{17'd0, 17'd4, 17'h1FF00, 17'h01000};   // Addresses 0x200 0x204 0x100 and 0x1200
    startProgram();
    emit(immInstr(`niuOpAddi, 5'd4, rZero, 17'h00200));
    for (k = 0; k < 4; k++) begin
        vals[k] = $urandom();
        loadConst(5'd1, vals[k]);
        emit(memInstr(`niuOpSw, 5'd1, 5'd4, offs[k]));   // No LED strobe expected
    end
    for (k = 3; k >= 0; k--) begin
        emit(memInstr(`niuOpLw, 5'd5, 5'd4, offs[k]));
        showReg(5'd5, vals[k]);
    end
    endProgram();
endfunction

function automatic void buildBranchProgram();
    opcodeT ops[9];
    int     xs[9];
    int     ys[9];
    wordT   vals[4];
    int     k;
    int     j;
    int     skip;
    logic   taken;
    ops = '{`niuOpBeq, `niuOpBeq, `niuOpBne, `niuOpBne, `niuOpBlt,
            `niuOpBlt, `niuOpBle, `niuOpBle, `niuOpBle};
    xs = '{1, 1, 1, 1, 1, 2, 1, 2, 1};
    ys = '{3, 2, 2, 3, 2, 1, 3, 1, 2};
    vals[0] = '0;
    vals[1] = $urandom() | 32'h8000_0000;
    vals[2] = ($urandom() & 32'h7FFF_FFFF) | 32'h1;
    vals[3] = vals[1];   // r3 is a copy of r1
    startProgram();
    loadConst(5'd1, vals[1]);
    loadConst(5'd2, vals[2]);
    emit(immInstr(`niuOpAddi, 5'd3, 5'd1, 17'd0));
    for (k = 0; k < 9; k++) begin
        skip  = 1 + (k / 2) % 2;   // Taken branches jump one or two words
        taken = branchTaken(ops[k], vals[xs[k]], vals[ys[k]]);
        emit(immInstr(`niuOpAddi, 5'd11, rZero, immT'(256 + k)));
        emit(immInstr(`niuOpAddi, 5'd12, rZero, immT'(512 + k)));
        emit(branchInstr(ops[k], regSelT'(xs[k]), regSelT'(ys[k]), immT'(skip)));
        for (j = 0; j < skip; j++) begin
            emit(memInstr(`niuOpSw, 5'd11, rLed, 17'd0));   // Fall-through marker
            if (!taken) begin
                expectQ.push_back(wordT'(256 + k));
            end
        end
        showReg(5'd12, wordT'(512 + k));   // Join marker
    end
    endProgram();
endfunction

function automatic void buildJalProgram();
    int jalIndex;
    startProgram();
    jalIndex = prog.size() + 1;
    emit(immInstr(`niuOpAddi, 5'd7, rZero, immT'((jalIndex + 3) * 4)));
    emit(jalInstr(5'd31, 5'd7));
    emit(memInstr(`niuOpSw, 5'd31, rLed, 17'd0));   // After the return
    emit({opIllegal, 27'd0});
    // Subroutine
    emit(immInstr(`niuOpAddi, 5'd8, rZero, 17'h005A5));
    showReg(5'd8, 32'h0000_05A5);
    emit(jalInstr(5'd6, 5'd31));
    expectQ.push_back(wordT'(jalIndex * 4 + 4));
    endProgram();
endfunction

function automatic void buildSwitchProgram(wordT sw);
    startProgram();
    emit(memInstr(`niuOpLw, 5'd5, rLed, 17'h00100));   // LED address plus 0x100
    showReg(5'd5, sw);
    emit(immInstr(`niuOpAddi, 5'd29, rZero, 17'h10120));
    emit(memInstr(`niuOpLw, 5'd6, 5'd29, 17'd0));
    showReg(5'd6, sw);
    endProgram();
endfunction

`endif

// ==== tests/niuCoreTb.sv ====
`timescale 1ns/100ps
`include "niu_defines.svh"

module niuCoreTb import niuPkg::*; ();

    logic     clk;
    logic     reset;
    logic     progWrite;
    memIndexT progAddr;
    wordT     progData;
    wordT     switches;
    logic     ledValid;
    wordT     ledData;
    logic     halted;

    wordT prog[$];      // Program under test
    wordT expectQ[$];   // LED values still to come
    int   instrTotal;
    int   cycleCount;
    int   mismatchCount;
    int   otherErrors;
    int   strobeCount;

    `include "niuProgramsTb.svh"

    niuCore i_dut (
        .clk       (clk),
        .reset     (reset),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .switches  (switches),
        .ledValid  (ledValid),
        .ledData   (ledData),
        .halted    (halted)
    );

    always #4 clk = ~clk;

    task automatic reportCounts();
        $display("Errors: %0d mismatches, %0d other failures, %0d LED strobes seen",
                 mismatchCount, otherErrors, strobeCount);
    endtask

    // Sampled mid-cycle, away from the edge
    always @(negedge clk) begin : ledMonitor
        wordT expected;
        if (!reset && ledValid) begin
            strobeCount++;
            assert (!halted) else begin
                $display("LED strobe while halted at %0t", $time);
                otherErrors++;
            end
            assert (expectQ.size() > 0) else begin
                $display("Unexpected LED strobe at %0t with ledData %h", $time, ledData);
                otherErrors++;
            end
            if (expectQ.size() > 0) begin
                expected = expectQ.pop_front();
                assert (ledData == expected) else begin
                    $display("MISMATCH at %0t ledData expected %h actual %h",
                             $time, expected, ledData);
                    mismatchCount++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > 8 * instrTotal + 200) begin
            $display("Timeout after %0d cycles without a halt", cycleCount);
            reportCounts();
            $display("Checks failed");
            $finish;
        end
    end

    // Load under reset, then run to the halt
    task automatic runProgram(input string name);
        int resetCycles;
        int c;
        resetCycles = (prog.size() > 4) ? prog.size() : 4;
        reset = 1'b1;
        for (c = 0; c < resetCycles; c++) begin
            @(posedge clk);
            #1;
            progWrite = (c < prog.size());
            progAddr  = memIndexT'(c);
            progData  = (c < prog.size()) ? prog[c] : '0;
        end
        @(posedge clk);
        #1;
        progWrite = 1'b0;
        reset     = 1'b0;
        while (!halted) begin
            @(posedge clk);
            #1;
        end
        assert (expectQ.size() == 0) else begin
            $display("%s program halted at %0t with %0d LED values missing",
                     name, $time, expectQ.size());
            otherErrors++;
        end
        expectQ.delete();
        repeat (6) begin
            @(posedge clk);
            #1;
            assert (halted) else begin
                $display("%s program left the halt state at %0t", name, $time);
                otherErrors++;
            end
        end
    endtask

    initial begin
        int k;
        clk           = 1'b0;
        reset         = 1'b1;
        progWrite     = 1'b0;
        progAddr      = '0;
        progData      = '0;
        switches      = '0;
        instrTotal    = 0;
        cycleCount    = 0;
        mismatchCount = 0;
        otherErrors   = 0;
        strobeCount   = 0;
        void'($urandom(52716));

        buildRegAluProgram();
        runProgram("register ALU");
        buildImmProgram();
        runProgram("immediate ALU");
        buildMemProgram();
        runProgram("load and store");
        buildBranchProgram();
        runProgram("branch");
        buildJalProgram();
        runProgram("JAL");
        for (k = 0; k < 3; k++) begin
            switches = $urandom();
            buildSwitchProgram(switches);
            runProgram("switch input");
        end

        reportCounts();
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
